/* logic/croc_pkg.sv */
package croc_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  // SRAM also serves as the boot location
  localparam logic [AddrWidth-1:0] SramBaseAddr = 32'h1000_0000;
  localparam int unsigned SramNumWords      = 512;
  localparam int unsigned SramWordAddrWidth = 9;
  // Byte address bits spanned by the SRAM
  localparam int unsigned SramWinBits       = SramWordAddrWidth + 2;

  localparam logic [AddrWidth-1:0] PeriphBase  = 32'h0300_0000;
  localparam logic [AddrWidth-1:0] SocCtrlBase = 32'h0300_0000;
  localparam logic [AddrWidth-1:0] GpioBase    = 32'h0300_5000;
  localparam logic [AddrWidth-1:0] TimerBase   = 32'h0300_A000;

  // 64 KiB peripheral space, 4 KiB per block
  localparam int unsigned PeriphSpaceBits = 16;
  localparam int unsigned PeriphWinBits   = 12;

  // ----------------------------------------------------------------------
  // Register offsets
  // ----------------------------------------------------------------------
  localparam int unsigned RegOffsetWidth = 5;

  localparam logic [RegOffsetWidth-1:0] BootAddrOffs = 5'h00;
  localparam logic [RegOffsetWidth-1:0] FetchEnOffs  = 5'h04;

  localparam logic [RegOffsetWidth-1:0] GpioOutOffs       = 5'h00;
  localparam logic [RegOffsetWidth-1:0] GpioOutEnOffs     = 5'h04;
  localparam logic [RegOffsetWidth-1:0] GpioInOffs        = 5'h08;
  localparam logic [RegOffsetWidth-1:0] GpioIrqEnOffs     = 5'h0C;
  localparam logic [RegOffsetWidth-1:0] GpioIrqStatusOffs = 5'h10;

  localparam logic [RegOffsetWidth-1:0] TimerCtrlOffs  = 5'h00;
  localparam logic [RegOffsetWidth-1:0] TimerCmpOffs   = 5'h04;
  localparam logic [RegOffsetWidth-1:0] TimerCountOffs = 5'h08;

  // ----------------------------------------------------------------------
  // Pins, interrupts, error response
  // ----------------------------------------------------------------------
  localparam int unsigned GpioCount = 16;

  localparam int unsigned NumIrqs  = 2;
  localparam int unsigned IrqTimer = 0;
  localparam int unsigned IrqGpio  = 1;

  // Returned for any unmapped access
  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADC_AB1E;

  typedef enum logic [2:0] {
    TgtSram,
    TgtSocCtrl,
    TgtGpio,
    TgtTimer,
    TgtError
  } bus_target_e;

endpackage

/* logic/bus_decode.sv */
module bus_decode import croc_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [AddrWidth-1:0]         addr_i,
  input  logic [DataWidth-1:0]         wdata_i,
  input  logic [BeWidth-1:0]           be_i,
  output logic                         rvalid_o,
  output logic [DataWidth-1:0]         rdata_o,
  output logic                         err_o,

  output logic                         tgt_we_o,
  output logic [DataWidth-1:0]         tgt_wdata_o,
  output logic [BeWidth-1:0]           tgt_be_o,

  output logic                         sram_req_o,
  output logic [SramWordAddrWidth-1:0] sram_addr_o,
  input  logic                         sram_rvalid_i,
  input  logic [DataWidth-1:0]         sram_rdata_i,

  output logic                         soc_req_o,
  output logic                         gpio_req_o,
  output logic                         timer_req_o,
  output logic [RegOffsetWidth-1:0]    reg_offs_o,
  input  logic                         soc_rvalid_i,
  input  logic [DataWidth-1:0]         soc_rdata_i,
  input  logic                         gpio_rvalid_i,
  input  logic [DataWidth-1:0]         gpio_rdata_i,
  input  logic                         timer_rvalid_i,
  input  logic [DataWidth-1:0]         timer_rdata_i
);

  bus_target_e tgt_sel, tgt_q;
  logic        err_req_q;
  logic [3:0]  tgt_req, tgt_rvalid;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  always_comb begin
    tgt_sel = TgtError;
    if (addr_i[AddrWidth-1:SramWinBits] == SramBaseAddr[AddrWidth-1:SramWinBits]) begin
      tgt_sel = TgtSram;
    end else if (addr_i[AddrWidth-1:PeriphSpaceBits] ==
                 PeriphBase[AddrWidth-1:PeriphSpaceBits]) begin
      // Holes between the blocks stay on the error target
      if (addr_i[AddrWidth-1:PeriphWinBits] == SocCtrlBase[AddrWidth-1:PeriphWinBits]) begin
        tgt_sel = TgtSocCtrl;
      end else if (addr_i[AddrWidth-1:PeriphWinBits] == GpioBase[AddrWidth-1:PeriphWinBits]) begin
        tgt_sel = TgtGpio;
      end else if (addr_i[AddrWidth-1:PeriphWinBits] == TimerBase[AddrWidth-1:PeriphWinBits]) begin
        tgt_sel = TgtTimer;
      end
    end
  end

  assign sram_req_o  = req_i && (tgt_sel == TgtSram);
  assign soc_req_o   = req_i && (tgt_sel == TgtSocCtrl);
  assign gpio_req_o  = req_i && (tgt_sel == TgtGpio);
  assign timer_req_o = req_i && (tgt_sel == TgtTimer);

  assign tgt_we_o    = we_i;
  assign tgt_wdata_o = wdata_i;
  assign tgt_be_o    = be_i;
  assign sram_addr_o = addr_i[SramWinBits-1:2];
  assign reg_offs_o  = addr_i[RegOffsetWidth-1:0];

  // Pending target, and the error responder's single slot
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tgt_q     <= TgtError;
      err_req_q <= 1'b0;
    end else begin
      tgt_q     <= tgt_sel;
      err_req_q <= req_i && (tgt_sel == TgtError);
    end
  end

  // ----------------------------------------------------------------------
  // Response mux
  // ----------------------------------------------------------------------
  always_comb begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    case (tgt_q)
      TgtSram: begin
        rvalid_o = sram_rvalid_i;
        rdata_o  = sram_rdata_i;
      end
      TgtSocCtrl: begin
        rvalid_o = soc_rvalid_i;
        rdata_o  = soc_rdata_i;
      end
      TgtGpio: begin
        rvalid_o = gpio_rvalid_i;
        rdata_o  = gpio_rdata_i;
      end
      TgtTimer: begin
        rvalid_o = timer_rvalid_i;
        rdata_o  = timer_rdata_i;
      end
      default: begin
        rvalid_o = err_req_q;
        err_o    = err_req_q;
        rdata_o  = err_req_q ? ErrRspData : '0;
      end
    endcase
  end

  assign tgt_req    = {sram_req_o, soc_req_o, gpio_req_o, timer_req_o};
  assign tgt_rvalid = {sram_rvalid_i, soc_rvalid_i, gpio_rvalid_i, timer_rvalid_i};

  // Every accepted request is answered in the next cycle
  assert property (@(posedge clk_i) disable iff (reset_i) req_i |=> rvalid_o);

  // A target may only answer the cycle after it was strobed
  assert property (@(posedge clk_i) disable iff (reset_i)
    (tgt_rvalid & ~$past(tgt_req)) == '0);

endmodule

/* logic/sram_bank.sv */
module sram_bank import croc_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [SramWordAddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]         wdata_i,
  input  logic [BeWidth-1:0]           be_i,
  output logic                         rvalid_o,
  output logic [DataWidth-1:0]         rdata_o
);

  logic [DataWidth-1:0] mem_q [SramNumWords];
  logic [DataWidth-1:0] rdata_q;
  logic                 rvalid_q;

  // Byte-masked write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    rdata_q <= (req_i && !we_i) ? mem_q[addr_i] : '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  assert property (@(posedge clk_i) disable iff (reset_i) (req_i && we_i) |-> (be_i != '0))
    else $warning("SRAM write with all byte enables clear");

endmodule

/* logic/soc_ctrl_regs.sv */
module soc_ctrl_regs import croc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [RegOffsetWidth-1:0] offs_i,
  input  logic [DataWidth-1:0]      wdata_i,
  input  logic                      fetch_en_i,
  output logic                      rvalid_o,
  output logic [DataWidth-1:0]      rdata_o,
  output logic [AddrWidth-1:0]      boot_addr_o,
  output logic                      fetch_enable_o
);

  logic [AddrWidth-1:0] boot_addr_q;
  logic                 fetch_en_q;
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_d, rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      boot_addr_q <= SramBaseAddr;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (req_i && we_i) begin
        case (offs_i)
          BootAddrOffs: boot_addr_q <= wdata_i;
          FetchEnOffs:  fetch_en_q  <= wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  // Unknown offsets read as zero
  always_comb begin
    rdata_d = '0;
    if (req_i && !we_i) begin
      case (offs_i)
        BootAddrOffs: rdata_d = boot_addr_q;
        FetchEnOffs:  rdata_d = {{(DataWidth-1){1'b0}}, fetch_en_q};
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign rvalid_o       = rvalid_q;
  assign rdata_o        = rdata_q;
  assign boot_addr_o    = boot_addr_q;
  // The pin can start the core without a bus write
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

/* logic/gpio_regs.sv */
module gpio_regs import croc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [RegOffsetWidth-1:0] offs_i,
  input  logic [DataWidth-1:0]      wdata_i,
  output logic                      rvalid_o,
  output logic [DataWidth-1:0]      rdata_o,
  input  logic [GpioCount-1:0]      gpio_i,
  output logic [GpioCount-1:0]      gpio_o,
  output logic [GpioCount-1:0]      gpio_out_en_o,
  output logic [GpioCount-1:0]      gpio_in_sync_o,
  output logic                      irq_o
);

  logic [GpioCount-1:0] out_q, out_en_q, irq_en_q, irq_status_q;
  logic [GpioCount-1:0] sync1_q, sync2_q, prev_q;
  logic [GpioCount-1:0] rise, status_clr;
  logic                 rvalid_q;
  logic [DataWidth-1:0] rdata_d, rdata_q;

  assign rise       = sync2_q & ~prev_q & irq_en_q;
  assign status_clr = (req_i && we_i && offs_i == GpioIrqStatusOffs) ?
                      wdata_i[GpioCount-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q        <= '0;
      out_en_q     <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
      sync1_q      <= '0;
      sync2_q      <= '0;
      prev_q       <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      // Two-flop synchronizer, then edge history
      sync1_q      <= gpio_i;
      sync2_q      <= sync1_q;
      prev_q       <= sync2_q;
      rvalid_q     <= req_i;
      // A new edge wins over a clear in the same cycle
      irq_status_q <= (irq_status_q & ~status_clr) | rise;
      if (req_i && we_i) begin
        case (offs_i)
          GpioOutOffs:   out_q    <= wdata_i[GpioCount-1:0];
          GpioOutEnOffs: out_en_q <= wdata_i[GpioCount-1:0];
          GpioIrqEnOffs: irq_en_q <= wdata_i[GpioCount-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    if (req_i && !we_i) begin
      case (offs_i)
        GpioOutOffs:       rdata_d = DataWidth'(out_q);
        GpioOutEnOffs:     rdata_d = DataWidth'(out_en_q);
        GpioInOffs:        rdata_d = DataWidth'(sync2_q);
        GpioIrqEnOffs:     rdata_d = DataWidth'(irq_en_q);
        GpioIrqStatusOffs: rdata_d = DataWidth'(irq_status_q);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign rvalid_o       = rvalid_q;
  assign rdata_o        = rdata_q;
  assign gpio_o         = out_q;
  assign gpio_out_en_o  = out_en_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |irq_status_q;

endmodule

/* logic/timer_unit.sv */
module timer_unit import croc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [RegOffsetWidth-1:0] offs_i,
  input  logic [DataWidth-1:0]      wdata_i,
  output logic                      rvalid_o,
  output logic [DataWidth-1:0]      rdata_o,
  output logic                      irq_o
);

  logic                 enable_q, irq_q, rvalid_q, match;
  logic [DataWidth-1:0] cmp_q, count_q;
  logic [DataWidth-1:0] rdata_d, rdata_q;

  assign match = enable_q && (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
      count_q  <= '0;
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      irq_q    <= match;
      // Wrap on match, so pulses come every cmp+1 cycles
      if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (req_i && we_i) begin
        case (offs_i)
          TimerCtrlOffs:  enable_q <= wdata_i[0];
          TimerCmpOffs:   cmp_q    <= wdata_i;
          TimerCountOffs: count_q  <= wdata_i;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    if (req_i && !we_i) begin
      case (offs_i)
        TimerCtrlOffs:  rdata_d = {{(DataWidth-1){1'b0}}, enable_q};
        TimerCmpOffs:   rdata_d = cmp_q;
        TimerCountOffs: rdata_d = count_q;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign irq_o    = irq_q;

  assert property (@(posedge clk_i) disable iff (reset_i) irq_o |=> !irq_o);

endmodule

/* logic/croc_domain.sv */
module croc_domain import croc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 fetch_en_i,

  // Bus from the external manager
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [BeWidth-1:0]   be_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o,

  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,

  output logic [NumIrqs-1:0]   irqs_o,
  output logic [AddrWidth-1:0] boot_addr_o,
  output logic                 fetch_enable_o
);

  // ----------------------------------------------------------------------
  // Target side of the decoder
  // ----------------------------------------------------------------------
  logic                         tgt_we;
  logic [DataWidth-1:0]         tgt_wdata;
  logic [BeWidth-1:0]           tgt_be;
  logic [RegOffsetWidth-1:0]    reg_offs;

  logic                         sram_req, sram_rvalid;
  logic [SramWordAddrWidth-1:0] sram_addr;
  logic [DataWidth-1:0]         sram_rdata;

  logic                         soc_req, soc_rvalid;
  logic [DataWidth-1:0]         soc_rdata;
  logic                         gpio_req, gpio_rvalid, gpio_irq;
  logic [DataWidth-1:0]         gpio_rdata;
  logic                         timer_req, timer_rvalid, timer_irq;
  logic [DataWidth-1:0]         timer_rdata;

  assign irqs_o[IrqTimer] = timer_irq;
  assign irqs_o[IrqGpio]  = gpio_irq;

  bus_decode i_bus_decode (
    .clk_i, .reset_i,
    .req_i, .we_i, .addr_i, .wdata_i, .be_i,
    .rvalid_o, .rdata_o, .err_o,
    .tgt_we_o       ( tgt_we       ),
    .tgt_wdata_o    ( tgt_wdata    ),
    .tgt_be_o       ( tgt_be       ),
    .sram_req_o     ( sram_req     ),
    .sram_addr_o    ( sram_addr    ),
    .sram_rvalid_i  ( sram_rvalid  ),
    .sram_rdata_i   ( sram_rdata   ),
    .soc_req_o      ( soc_req      ),
    .gpio_req_o     ( gpio_req     ),
    .timer_req_o    ( timer_req    ),
    .reg_offs_o     ( reg_offs     ),
    .soc_rvalid_i   ( soc_rvalid   ),
    .soc_rdata_i    ( soc_rdata    ),
    .gpio_rvalid_i  ( gpio_rvalid  ),
    .gpio_rdata_i   ( gpio_rdata   ),
    .timer_rvalid_i ( timer_rvalid ),
    .timer_rdata_i  ( timer_rdata  )
  );

  sram_bank i_sram (
    .clk_i, .reset_i,
    .req_i    ( sram_req    ),
    .we_i     ( tgt_we      ),
    .addr_i   ( sram_addr   ),
    .wdata_i  ( tgt_wdata   ),
    .be_i     ( tgt_be      ),
    .rvalid_o ( sram_rvalid ),
    .rdata_o  ( sram_rdata  )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i, .reset_i, .fetch_en_i, .boot_addr_o, .fetch_enable_o,
    .req_i    ( soc_req    ),
    .we_i     ( tgt_we     ),
    .offs_i   ( reg_offs   ),
    .wdata_i  ( tgt_wdata  ),
    .rvalid_o ( soc_rvalid ),
    .rdata_o  ( soc_rdata  )
  );

  gpio_regs i_gpio (
    .clk_i, .reset_i, .gpio_i, .gpio_o, .gpio_out_en_o, .gpio_in_sync_o,
    .req_i    ( gpio_req    ),
    .we_i     ( tgt_we      ),
    .offs_i   ( reg_offs    ),
    .wdata_i  ( tgt_wdata   ),
    .rvalid_o ( gpio_rvalid ),
    .rdata_o  ( gpio_rdata  ),
    .irq_o    ( gpio_irq    )
  );

  timer_unit i_timer (
    .clk_i, .reset_i,
    .req_i    ( timer_req    ),
    .we_i     ( tgt_we       ),
    .offs_i   ( reg_offs     ),
    .wdata_i  ( tgt_wdata    ),
    .rvalid_o ( timer_rvalid ),
    .rdata_o  ( timer_rdata  ),
    .irq_o    ( timer_irq    )
  );

endmodule

/* test/tb_croc_domain.sv */
module tb_croc_domain import croc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // Roughly 3000 cycles of traffic and a wide margin
  localparam int unsigned CycleLimit = 20000;
  localparam int unsigned SramOps    = 300;
  localparam int unsigned ErrOps     = 100;

  logic                 clk_i;
  logic                 reset_i;
  logic                 fetch_en_i;
  logic                 req_i;
  logic                 we_i;
  logic [AddrWidth-1:0] addr_i;
  logic [DataWidth-1:0] wdata_i;
  logic [BeWidth-1:0]   be_i;
  logic                 rvalid_o;
  logic [DataWidth-1:0] rdata_o;
  logic                 err_o;
  logic [GpioCount-1:0] gpio_i;
  logic [GpioCount-1:0] gpio_o;
  logic [GpioCount-1:0] gpio_out_en_o;
  logic [GpioCount-1:0] gpio_in_sync_o;
  logic [NumIrqs-1:0]   irqs_o;
  logic [AddrWidth-1:0] boot_addr_o;
  logic                 fetch_enable_o;

  logic [31:0]          rng_state = 32'he3ac;
  logic [DataWidth-1:0] sram_model [SramNumWords];
  int unsigned          cycle_cnt = 0;

  croc_domain croc_domain_i (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      abort_run($sformatf("Timeout: the tests did not finish within %0d cycles", CycleLimit));
    end
  end

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h",
                          $time, name, actual, expected));
    end
  endtask

  // xorshift32
  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
  endfunction

  // Windows as given by the address map
  function automatic logic is_mapped(input logic [31:0] a);
    if (a >= SramBaseAddr && a < SramBaseAddr + SramNumWords * 4) return 1'b1;
    if (a[31:12] == SocCtrlBase[31:12]) return 1'b1;
    if (a[31:12] == GpioBase[31:12]) return 1'b1;
    if (a[31:12] == TimerBase[31:12]) return 1'b1;
    return 1'b0;
  endfunction

  // Issues one request and expects its response exactly one cycle later
  task automatic send_request(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= wr;
    addr_i  <= addr;
    wdata_i <= data;
    be_i    <= be;
    @(negedge clk_i);
    check_value("rvalid_o before acceptance", rvalid_o, 1'b0);
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    @(negedge clk_i);
    check_value("rvalid_o", rvalid_o, 1'b1);
    rdata = rdata_o;
    err   = err_o;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
    logic [31:0] rd;
    logic        err;
    send_request(1'b1, addr, data, be, rd, err);
    check_value("err_o", err, 1'b0);
    check_value("rdata_o on write", rd, 32'h0);
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    send_request(1'b0, addr, 32'h0, 4'hF, data, err);
    check_value("err_o", err, 1'b0);
  endtask

  // --------------------------------------------------------------------
  // Test sequences
  // --------------------------------------------------------------------
  task automatic reset_value_checks();
    check_value("rvalid_o", rvalid_o, 1'b0);
    check_value("err_o", err_o, 1'b0);
    check_value("gpio_o", gpio_o, '0);
    check_value("gpio_out_en_o", gpio_out_en_o, '0);
    check_value("irqs_o", irqs_o, '0);
    check_value("fetch_enable_o", fetch_enable_o, 1'b0);
    check_value("boot_addr_o", boot_addr_o, SramBaseAddr);
  endtask

  task automatic soc_ctrl_checks();
    logic [31:0] rd, boot, r;
    logic        fe_reg, fe_pin;
    read_word(SocCtrlBase + BootAddrOffs, rd);
    check_value("BOOT_ADDR", rd, SramBaseAddr);
    boot = rand32();
    write_word(SocCtrlBase + BootAddrOffs, boot, 4'hF);
    check_value("boot_addr_o", boot_addr_o, boot);
    read_word(SocCtrlBase + BootAddrOffs, rd);
    check_value("BOOT_ADDR", rd, boot);
    for (int c = 0; c < 4; c++) begin
      fe_reg = c[0];
      fe_pin = c[1];
      r = rand32();
      write_word(SocCtrlBase + FetchEnOffs, {r[31:1], fe_reg}, 4'hF);
      @(posedge clk_i);
      fetch_en_i <= fe_pin;
      @(negedge clk_i);
      check_value("fetch_enable_o", fetch_enable_o, fe_reg | fe_pin);
      read_word(SocCtrlBase + FetchEnOffs, rd);
      check_value("FETCHEN", rd, {31'b0, fe_reg});
    end
    @(posedge clk_i);
    fetch_en_i <= 1'b0;
  endtask

  task automatic sram_traffic();
    logic [31:0] addr, data, r, rd;
    logic [3:0]  be;
    int unsigned widx, ridx;
    for (int unsigned i = 0; i < SramNumWords; i++) begin
      addr          = SramBaseAddr + (i << 2);
      sram_model[i] = fill_word(addr);
      write_word(addr, sram_model[i], 4'hF);
    end
    for (int i = 0; i < SramOps; i++) begin
      r    = rand32();
      widx = r % SramNumWords;
      // Skip the empty mask
      be   = (r[31:28] == 4'h0) ? 4'h1 : r[31:28];
      data = rand32();
      for (int b = 0; b < BeWidth; b++) begin
        if (be[b]) sram_model[widx][8*b +: 8] = data[8*b +: 8];
      end
      write_word(SramBaseAddr + (widx << 2), data, be);
      ridx = r[20] ? widx : (rand32() % SramNumWords);
      read_word(SramBaseAddr + (ridx << 2), rd);
      check_value("rdata_o", rd, sram_model[ridx]);
    end
  endtask

  task automatic unmapped_traffic();
    logic [31:0] addr, data, rd, r;
    logic        err;
    int unsigned idx;
    for (int i = 0; i < ErrOps; i++) begin
      do begin
        r = rand32();
        case (i % 3)
          0: addr = rand32();
          1: addr = {PeriphBase[31:16], r[15:0]};
          default: addr = SramBaseAddr + SramNumWords * 4 + {r[10:2], 2'b00};
        endcase
      end while (is_mapped(addr));
      data = rand32();
      send_request(data[0], addr, data, 4'hF, rd, err);
      check_value("err_o", err, 1'b1);
      check_value("rdata_o on error", rd, ErrRspData);
    end
    // SRAM must not have seen any of these
    repeat (32) begin
      r   = rand32();
      idx = r % SramNumWords;
      read_word(SramBaseAddr + (idx << 2), rd);
      check_value("rdata_o", rd, sram_model[idx]);
    end
  endtask

  task automatic gpio_data_checks();
    logic [31:0]          out, oen, rd, r;
    logic [GpioCount-1:0] pins, prev;
    repeat (8) begin
      out = rand32();
      oen = rand32();
      write_word(GpioBase + GpioOutOffs, out, 4'hF);
      write_word(GpioBase + GpioOutEnOffs, oen, 4'hF);
      check_value("gpio_o", gpio_o, out[GpioCount-1:0]);
      check_value("gpio_out_en_o", gpio_out_en_o, oen[GpioCount-1:0]);
      read_word(GpioBase + GpioOutOffs, rd);
      check_value("GPIO_OUT", rd, out[GpioCount-1:0]);
      read_word(GpioBase + GpioOutEnOffs, rd);
      check_value("GPIO_OUT_EN", rd, oen[GpioCount-1:0]);
    end
    // Pins have been low since the start of the run
    prev = '0;
    repeat (8) begin
      r    = rand32();
      pins = r[GpioCount-1:0];
      @(posedge clk_i);
      gpio_i <= pins;
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("gpio_in_sync_o after one cycle", gpio_in_sync_o, prev);
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("gpio_in_sync_o", gpio_in_sync_o, pins);
      read_word(GpioBase + GpioInOffs, rd);
      check_value("GPIO_IN", rd, pins);
      prev = pins;
    end
  endtask

  task automatic gpio_irq_checks();
    logic [31:0]          r, rd;
    logic [GpioCount-1:0] mask, pattern, expected;
    repeat (6) begin
      @(posedge clk_i);
      gpio_i <= '0;
      repeat (4) @(posedge clk_i);
      r       = rand32();
      mask    = r[GpioCount-1:0];
      pattern = r[2*GpioCount-1:GpioCount];
      write_word(GpioBase + GpioIrqEnOffs, mask, 4'hF);
      @(posedge clk_i);
      gpio_i <= pattern;
      // Two synchronizer stages plus the status flop
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      expected = pattern & mask;
      check_value("irqs_o[IrqGpio]", irqs_o[IrqGpio], |expected);
      read_word(GpioBase + GpioIrqStatusOffs, rd);
      check_value("GPIO_IRQ_STATUS", rd, expected);
      write_word(GpioBase + GpioIrqStatusOffs, expected, 4'hF);
      check_value("irqs_o[IrqGpio] after clear", irqs_o[IrqGpio], 1'b0);
      read_word(GpioBase + GpioIrqStatusOffs, rd);
      check_value("GPIO_IRQ_STATUS after clear", rd, 32'h0);
    end
  endtask

  task automatic wait_timer_pulse(input logic [31:0] cmp, output int unsigned at);
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    while (irqs_o[IrqTimer] !== 1'b1) begin
      if (waited > 2 * (cmp + 1)) begin
        abort_run("Timer interrupt did not arrive within two timer periods");
      end
      waited++;
      @(negedge clk_i);
    end
    at = cycle_cnt;
    @(negedge clk_i);
    check_value("irqs_o[IrqTimer] pulse width", irqs_o[IrqTimer], 1'b0);
  endtask

  task automatic timer_checks();
    logic [31:0] cmp, rd, r;
    int unsigned last, now;
    r   = rand32();
    cmp = 3 + (r % 16);
    write_word(TimerBase + TimerCmpOffs, cmp, 4'hF);
    write_word(TimerBase + TimerCountOffs, 32'h0, 4'hF);
    read_word(TimerBase + TimerCmpOffs, rd);
    check_value("TIMER_CMP", rd, cmp);
    write_word(TimerBase + TimerCtrlOffs, 32'h1, 4'hF);
    wait_timer_pulse(cmp, last);
    repeat (4) begin
      wait_timer_pulse(cmp, now);
      check_value("timer pulse interval", now - last, cmp + 1);
      last = now;
    end
    write_word(TimerBase + TimerCtrlOffs, 32'h0, 4'hF);
    // A match just before the disable may still show for one cycle
    @(posedge clk_i);
    repeat (3 * (cmp + 1)) begin
      @(negedge clk_i);
      check_value("irqs_o[IrqTimer] while disabled", irqs_o[IrqTimer], 1'b0);
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    fetch_en_i = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    be_i       = '0;
    gpio_i     = '0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    reset_value_checks();
    soc_ctrl_checks();
    sram_traffic();
    unmapped_traffic();
    gpio_data_checks();
    gpio_irq_checks();
    timer_checks();
    $display(">>> PASS");
    $finish;
  end

endmodule

/* all.f */
logic/croc_pkg.sv
logic/bus_decode.sv
logic/sram_bank.sv
logic/soc_ctrl_regs.sv
logic/gpio_regs.sv
logic/timer_unit.sv
logic/croc_domain.sv
test/tb_croc_domain.sv

/* Bender.yml */
package:
  name: croc_domain

sources:
  # Package first, then the blocks, then the top level
  - logic/croc_pkg.sv
  - logic/bus_decode.sv
  - logic/sram_bank.sv
  - logic/soc_ctrl_regs.sv
  - logic/gpio_regs.sv
  - logic/timer_unit.sv
  - logic/croc_domain.sv

  - target: test
    files:
      - test/tb_croc_domain.sv
